//--- hw/arm_pkg.sv
package arm_pkg;

	localparam int word_len          = 32;
	localparam int reg_addr_len      = 4;
	localparam int exec_cmd_len      = 4;
	localparam int imm_len           = 24;
	localparam int shift_operand_len = 12;

	typedef logic [word_len-1:0]                word_t;
	typedef logic [reg_addr_len-1:0]            reg_addr_t;
	// N Z C V, N in the top bit
	typedef logic [3:0]                         status_t;
	typedef logic signed [imm_len-1:0]          imm24_t;
	typedef logic [shift_operand_len-1:0]       shift_operand_t;

	// Execute commands; LDR and STR reuse cmd_add
	typedef enum logic [exec_cmd_len-1:0] {
		cmd_none = 4'b0000,
		cmd_mov  = 4'b0001,
		cmd_add  = 4'b0010,
		cmd_adc  = 4'b0011,
		cmd_sub  = 4'b0100,
		cmd_sbc  = 4'b0101,
		cmd_and  = 4'b0110,
		cmd_orr  = 4'b0111,
		cmd_eor  = 4'b1000,
		cmd_mvn  = 4'b1001,
		cmd_cmp  = 4'b1100,
		cmd_tst  = 4'b1110
	} exec_cmd_e;

	// Data-processing opcodes, instruction bits 24..21
	typedef enum logic [3:0] {
		op_and = 4'b0000,
		op_eor = 4'b0001,
		op_sub = 4'b0010,
		op_add = 4'b0100,
		op_adc = 4'b0101,
		op_sbc = 4'b0110,
		op_tst = 4'b1000,
		op_cmp = 4'b1010,
		op_orr = 4'b1100,
		op_mov = 4'b1101,
		op_mvn = 4'b1111
	} opcode_e;

	typedef enum logic [3:0] {
		cond_eq, cond_ne, cond_cs, cond_cc,
		cond_mi, cond_pl, cond_vs, cond_vc,
		cond_hi, cond_ls, cond_ge, cond_lt,
		cond_gt, cond_le, cond_al, cond_nv
	} cond_e;

	typedef struct packed {
		exec_cmd_e exec_cmd;
		logic      mem_read;
		logic      mem_write;
		logic      imm;
		logic      wb_en;
		logic      branch;
		logic      status_wr;
	} ctrl_t;

	typedef struct packed {
		word_t          pc;
		ctrl_t          ctrl;
		word_t          rn_val;
		word_t          rm_val;
		reg_addr_t      rn;
		reg_addr_t      src2;
		reg_addr_t      dest;
		logic           two_src;
		imm24_t         imm24;
		shift_operand_t shift_operand;
	} id_out_t;

endpackage

//--- hw/control_unit.sv
module control_unit (
	input  logic [1:0]       mode,
	input  arm_pkg::opcode_e opcode,
	input  logic             s_bit,
	input  logic             imm_bit,
	output arm_pkg::ctrl_t   ctrl
);

	import arm_pkg::*;

	exec_cmd_e dp_cmd;

	// Opcode to execute command
	always_comb begin
		case (opcode)
			op_mov:  dp_cmd = cmd_mov;
			op_mvn:  dp_cmd = cmd_mvn;
			op_add:  dp_cmd = cmd_add;
			op_adc:  dp_cmd = cmd_adc;
			op_sub:  dp_cmd = cmd_sub;
			op_sbc:  dp_cmd = cmd_sbc;
			op_and:  dp_cmd = cmd_and;
			op_orr:  dp_cmd = cmd_orr;
			op_eor:  dp_cmd = cmd_eor;
			op_cmp:  dp_cmd = cmd_cmp;
			op_tst:  dp_cmd = cmd_tst;
			default: dp_cmd = cmd_none;
		endcase
	end

	always_comb begin
		ctrl = '0;
		case (mode)
			2'b00: begin
				ctrl.exec_cmd  = dp_cmd;
				ctrl.status_wr = s_bit;
				ctrl.imm       = imm_bit;
				// Compare and test only set flags
				ctrl.wb_en     = !(dp_cmd inside {cmd_none, cmd_cmp, cmd_tst});
			end
			2'b01: begin
				// Address is base plus offset
				ctrl.exec_cmd = cmd_add;
				ctrl.imm      = 1'b1;
				if (s_bit) begin
					ctrl.mem_read = 1'b1;
					ctrl.wb_en    = 1'b1;
				end else begin
					ctrl.mem_write = 1'b1;
				end
			end
			2'b10: begin
				ctrl.branch = 1'b1;
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule

//--- hw/cond_check.sv
module cond_check (
	input  arm_pkg::cond_e   cond,
	input  arm_pkg::status_t status,
	output logic             pass
);

	import arm_pkg::*;

	logic n;
	logic z;
	logic c;
	logic v;

	assign {n, z, c, v} = status;

	always_comb begin
		case (cond)
			cond_eq: pass = z;
			cond_ne: pass = !z;
			cond_cs: pass = c;
			cond_cc: pass = !c;
			cond_mi: pass = n;
			cond_pl: pass = !n;
			cond_vs: pass = v;
			cond_vc: pass = !v;
			cond_hi: pass = c && !z;
			cond_ls: pass = !c || z;
			cond_ge: pass = (n == v);
			cond_lt: pass = (n != v);
			cond_gt: pass = !z && (n == v);
			cond_le: pass = z || (n != v);
			cond_al: pass = 1'b1;
			// NV never executes
			default: pass = 1'b0;
		endcase
	end

endmodule

//--- hw/register_file.sv
module register_file (
	input  logic               clk,
	input  logic               reset,
	input  arm_pkg::reg_addr_t src1,
	input  arm_pkg::reg_addr_t src2,
	input  logic               wb_en,
	input  arm_pkg::reg_addr_t wb_dest,
	input  arm_pkg::word_t     wb_value,
	output arm_pkg::word_t     val1,
	output arm_pkg::word_t     val2
);

	import arm_pkg::*;

	word_t regs [2**reg_addr_len];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 2**reg_addr_len; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en) begin
			regs[wb_dest] <= wb_value;
		end
	end

	// No bypass, a write shows up the next cycle
	assign val1 = regs[src1];
	assign val2 = regs[src2];

endmodule

//--- hw/id_stage.sv
module id_stage (
	input  logic               clk,
	input  logic               reset,
	input  arm_pkg::word_t     pc,
	input  arm_pkg::word_t     instruction,
	input  arm_pkg::status_t   status,
	input  logic               hazard,
	input  logic               wb_en,
	input  arm_pkg::reg_addr_t wb_dest,
	input  arm_pkg::word_t     wb_value,
	output arm_pkg::id_out_t   id
);

	import arm_pkg::*;

	logic [1:0] mode;
	logic       imm_bit;
	logic       s_bit;
	opcode_e    opcode;
	cond_e      cond;

	ctrl_t      ctrl;
	logic       cond_pass;
	logic       squash;
	reg_addr_t  src1;
	reg_addr_t  src2;
	word_t      val1;
	word_t      val2;

	// Instruction fields
	assign cond    = cond_e'(instruction[31:28]);
	assign mode    = instruction[27:26];
	assign imm_bit = instruction[25];
	assign opcode  = opcode_e'(instruction[24:21]);
	assign s_bit   = instruction[20];

	control_unit i_ctrl (
		.mode    (mode),
		.opcode  (opcode),
		.s_bit   (s_bit),
		.imm_bit (imm_bit),
		.ctrl    (ctrl)
	);

	cond_check i_cond (
		.cond   (cond),
		.status (status),
		.pass   (cond_pass)
	);

	// Store reads Rd as its data source
	assign src1 = instruction[19:16];
	assign src2 = ctrl.mem_write ? instruction[15:12] : instruction[3:0];

	register_file i_regs (
		.clk      (clk),
		.reset    (reset),
		.src1     (src1),
		.src2     (src2),
		.wb_en    (wb_en),
		.wb_dest  (wb_dest),
		.wb_value (wb_value),
		.val1     (val1),
		.val2     (val2)
	);

	assign squash = hazard || !cond_pass;

	always_comb begin
		id.pc            = pc;
		id.ctrl          = squash ? '0 : ctrl;
		id.rn_val        = val1;
		id.rm_val        = val2;
		id.rn            = src1;
		id.src2          = src2;
		id.dest          = instruction[15:12];
		id.two_src       = !imm_bit || ctrl.mem_write;
		id.imm24         = instruction[imm_len-1:0];
		id.shift_operand = instruction[shift_operand_len-1:0];
	end

endmodule

//--- hw/id_ex_reg.sv
module id_ex_reg (
	input  logic             clk,
	input  logic             reset,
	input  logic             flush,
	input  arm_pkg::id_out_t d,
	output arm_pkg::id_out_t q
);

	always_ff @(posedge clk) begin
		if (reset) begin
			q <= '0;
		end else begin
			q <= d;
			// Bubble keeps the data fields
			if (flush) begin
				q.ctrl <= '0;
			end
		end
	end

endmodule

//--- hw/decode_top.sv
module decode_top (
	input  logic               clk,
	input  logic               reset,
	input  arm_pkg::word_t     pc,
	input  arm_pkg::word_t     instruction,
	input  arm_pkg::status_t   status,
	input  logic               hazard,
	input  logic               flush,
	input  logic               wb_en,
	input  arm_pkg::reg_addr_t wb_dest,
	input  arm_pkg::word_t     wb_value,
	output arm_pkg::id_out_t   ex,
	output arm_pkg::reg_addr_t rn,
	output arm_pkg::reg_addr_t src2
);

	import arm_pkg::*;

	id_out_t id;

	id_stage i_id (
		.clk         (clk),
		.reset       (reset),
		.pc          (pc),
		.instruction (instruction),
		.status      (status),
		.hazard      (hazard),
		.wb_en       (wb_en),
		.wb_dest     (wb_dest),
		.wb_value    (wb_value),
		.id          (id)
	);

	id_ex_reg i_id_ex (
		.clk   (clk),
		.reset (reset),
		.flush (flush),
		.d     (id),
		.q     (ex)
	);

	// Sources for the hazard unit, same cycle
	assign rn   = id.rn;
	assign src2 = id.src2;

endmodule

//--- verif/decode_tb.sv
module decode_tb;

	import arm_pkg::*;

	typedef struct packed {
		word_t     instruction;
		status_t   status;
		logic      hazard;
		logic      flush;
		logic      wb_en;
		reg_addr_t wb_dest;
		word_t     wb_value;
		ctrl_t     exp_ctrl;
		word_t     exp_rn_val;
		word_t     exp_rm_val;
		reg_addr_t exp_src2;
		logic      exp_two_src;
	} test_t;

	logic      clk;
	logic      reset;
	word_t     pc;
	word_t     instruction;
	status_t   status;
	logic      hazard;
	logic      flush;
	logic      wb_en;
	reg_addr_t wb_dest;
	word_t     wb_value;
	id_out_t   ex;
	reg_addr_t rn;
	reg_addr_t src2;

	test_t tests [$];
	// Slot 0 is the reset test, table entry i sits in slot i + 1
	string names [$];
	int    errs [$];
	word_t model [16];
	int    seed;
	int    pass_count;
	int    fail_count;

	decode_top i_dut (
		.clk         (clk),
		.reset       (reset),
		.pc          (pc),
		.instruction (instruction),
		.status      (status),
		.hazard      (hazard),
		.flush       (flush),
		.wb_en       (wb_en),
		.wb_dest     (wb_dest),
		.wb_value    (wb_value),
		.ex          (ex),
		.rn          (rn),
		.src2        (src2)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic cond_holds(cond_e c, status_t s);
		logic n;
		logic z;
		logic cf;
		logic v;
		{n, z, cf, v} = s;
		case (c)
			cond_eq: return z;
			cond_ne: return !z;
			cond_cs: return cf;
			cond_cc: return !cf;
			cond_mi: return n;
			cond_pl: return !n;
			cond_vs: return v;
			cond_vc: return !v;
			cond_hi: return cf && !z;
			cond_ls: return !cf || z;
			cond_ge: return n == v;
			cond_lt: return n != v;
			cond_gt: return !z && (n == v);
			cond_le: return z || (n != v);
			cond_al: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic word_t dp_instr(cond_e c, opcode_e op, logic i, logic s,
			reg_addr_t rn_idx, reg_addr_t rd, shift_operand_t op2);
		return {c, 2'b00, i, op, s, rn_idx, rd, op2};
	endfunction

	function automatic word_t mem_instr(logic load, reg_addr_t rn_idx, reg_addr_t rd,
			shift_operand_t off);
		return {cond_al, 2'b01, 1'b0, 4'b1100, load, rn_idx, rd, off};
	endfunction

	function automatic ctrl_t dp_ctrl(exec_cmd_e cmd, logic wb, logic s, logic i);
		ctrl_t c;
		c = '0;
		c.exec_cmd  = cmd;
		c.wb_en     = wb;
		c.status_wr = s;
		c.imm       = i;
		return c;
	endfunction

	function automatic ctrl_t mem_ctrl(logic load);
		ctrl_t c;
		c = '0;
		c.exec_cmd  = cmd_add;
		c.imm       = 1'b1;
		c.mem_read  = load;
		c.wb_en     = load;
		c.mem_write = !load;
		return c;
	endfunction

	function automatic word_t pc_of(int i);
		return word_t'(i << 2) + 32'h0000_1000;
	endfunction

	// Expected values come from the register model before this entry's write
	task automatic add_test(string name, word_t instr, status_t st, logic hz, logic fl,
			logic we, reg_addr_t wd, word_t wv, ctrl_t base);
		test_t     t;
		logic      is_store;
		reg_addr_t s2;
		is_store = (instr[27:26] == 2'b01) && !instr[20];
		s2 = is_store ? instr[15:12] : instr[3:0];
		t.instruction = instr;
		t.status      = st;
		t.hazard      = hz;
		t.flush       = fl;
		t.wb_en       = we;
		t.wb_dest     = wd;
		t.wb_value    = wv;
		if (hz || fl || !cond_holds(cond_e'(instr[31:28]), st))
			t.exp_ctrl = ctrl_t'('0);
		else
			t.exp_ctrl = base;
		t.exp_rn_val  = model[instr[19:16]];
		t.exp_rm_val  = model[s2];
		t.exp_src2    = s2;
		t.exp_two_src = !instr[25] || is_store;
		if (we)
			model[wd] = wv;
		tests.push_back(t);
		names.push_back(name);
		errs.push_back(0);
	endtask

	task automatic add_dp(string name, opcode_e op, exec_cmd_e cmd, logic wb, logic s,
			logic i, reg_addr_t rn_idx, reg_addr_t rm_idx);
		add_test(name, dp_instr(cond_al, op, i, s, rn_idx, 4'd3, {8'h5a, rm_idx}),
			4'b0000, 1'b0, 1'b0, 1'b0, 4'd0, '0, dp_ctrl(cmd, wb, s, i));
	endtask

	task automatic build_table();
		ctrl_t     br;
		cond_e     ce;
		word_t     rnd;
		word_t     val;
		reg_addr_t dest;
		reg_addr_t prev;
		foreach (model[r])
			model[r] = '0;
		// Reads of all sixteen registers while still at reset value
		add_dp("dp AND", op_and, cmd_and, 1'b1, 1'b0, 1'b0, 4'd0, 4'd15);
		add_dp("dp EOR", op_eor, cmd_eor, 1'b1, 1'b1, 1'b0, 4'd1, 4'd14);
		add_dp("dp SUB", op_sub, cmd_sub, 1'b1, 1'b0, 1'b1, 4'd2, 4'd13);
		add_dp("dp ADD", op_add, cmd_add, 1'b1, 1'b1, 1'b1, 4'd3, 4'd12);
		add_dp("dp ADC", op_adc, cmd_adc, 1'b1, 1'b0, 1'b0, 4'd4, 4'd11);
		add_dp("dp SBC", op_sbc, cmd_sbc, 1'b1, 1'b1, 1'b0, 4'd5, 4'd10);
		add_dp("dp TST", op_tst, cmd_tst, 1'b0, 1'b1, 1'b1, 4'd6, 4'd9);
		add_dp("dp CMP", op_cmp, cmd_cmp, 1'b0, 1'b1, 1'b0, 4'd7, 4'd8);
		add_dp("dp ORR", op_orr, cmd_orr, 1'b1, 1'b0, 1'b1, 4'd8, 4'd7);
		add_dp("dp MOV", op_mov, cmd_mov, 1'b1, 1'b1, 1'b0, 4'd9, 4'd6);
		add_dp("dp MVN", op_mvn, cmd_mvn, 1'b1, 1'b0, 1'b1, 4'd10, 4'd5);
		add_test("mem LDR", mem_instr(1'b1, 4'd4, 4'd5, 12'h010), 4'b0000, 1'b0, 1'b0,
			1'b0, 4'd0, '0, mem_ctrl(1'b1));
		add_test("mem STR", mem_instr(1'b0, 4'd6, 4'd7, 12'h008), 4'b0000, 1'b0, 1'b0,
			1'b0, 4'd0, '0, mem_ctrl(1'b0));
		br = '0;
		br.branch = 1'b1;
		add_test("branch", {cond_al, 4'b1010, 24'h80_0123}, 4'b0000, 1'b0, 1'b0,
			1'b0, 4'd0, '0, br);
		for (int k = 0; k < 16; k++) begin
			ce = cond_e'(k[3:0]);
			rnd = $random(seed);
			add_test($sformatf("cond %s", ce.name()),
				dp_instr(ce, op_add, 1'b1, 1'b1, 4'd2, 4'd4, 12'h009), rnd[3:0],
				1'b0, 1'b0, 1'b0, 4'd0, '0, dp_ctrl(cmd_add, 1'b1, 1'b1, 1'b1));
		end
		// Rn reads the previous write, Rm the register written in the same cycle
		prev = 4'd0;
		for (int k = 0; k < 10; k++) begin
			rnd = $random(seed);
			val = $random(seed);
			dest = rnd[3:0];
			add_test($sformatf("regfile %0d", k),
				dp_instr(cond_al, op_mov, 1'b0, 1'b0, prev, 4'd1, {8'h00, dest}),
				4'b0000, 1'b0, 1'b0, 1'b1, dest, val, dp_ctrl(cmd_mov, 1'b1, 1'b0, 1'b0));
			prev = dest;
		end
		add_test("squash hazard", dp_instr(cond_al, op_add, 1'b0, 1'b1, prev, 4'd2,
			{8'h00, dest}), 4'b0000, 1'b1, 1'b0, 1'b0, 4'd0, '0,
			dp_ctrl(cmd_add, 1'b1, 1'b1, 1'b0));
		add_test("squash flush", dp_instr(cond_al, op_orr, 1'b0, 1'b0, dest, 4'd2,
			{8'h00, prev}), 4'b0000, 1'b0, 1'b1, 1'b0, 4'd0, '0,
			dp_ctrl(cmd_orr, 1'b1, 1'b0, 1'b0));
	endtask

	task automatic check_ctrl(int idx, string field, ctrl_t exp, ctrl_t act);
		if (exp !== act) begin
			$display("[ERROR] %s %s: expected %h, actual %h", names[idx], field, exp, act);
			errs[idx]++;
		end
	endtask

	task automatic check_word(int idx, string field, word_t exp, word_t act);
		if (exp !== act) begin
			$display("[ERROR] %s %s: expected %h, actual %h", names[idx], field, exp, act);
			errs[idx]++;
		end
	endtask

	task automatic check_reg_addr(int idx, string field, reg_addr_t exp, reg_addr_t act);
		if (exp !== act) begin
			$display("[ERROR] %s %s: expected %h, actual %h", names[idx], field, exp, act);
			errs[idx]++;
		end
	endtask

	task automatic check_imm24(int idx, string field, imm24_t exp, imm24_t act);
		if (exp !== act) begin
			$display("[ERROR] %s %s: expected %h, actual %h", names[idx], field, exp, act);
			errs[idx]++;
		end
	endtask

	task automatic check_shift_operand(int idx, string field, shift_operand_t exp,
			shift_operand_t act);
		if (exp !== act) begin
			$display("[ERROR] %s %s: expected %h, actual %h", names[idx], field, exp, act);
			errs[idx]++;
		end
	endtask

	task automatic check_bit(int idx, string field, logic exp, logic act);
		if (exp !== act) begin
			$display("[ERROR] %s %s: expected %b, actual %b", names[idx], field, exp, act);
			errs[idx]++;
		end
	endtask

	task automatic check_bundle(int idx, string field, id_out_t exp, id_out_t act);
		if (exp !== act) begin
			$display("[ERROR] %s %s: expected %h, actual %h", names[idx], field, exp, act);
			errs[idx]++;
		end
	endtask

	task automatic drive(int i);
		test_t t;
		t = tests[i];
		pc          <= pc_of(i);
		instruction <= t.instruction;
		status      <= t.status;
		hazard      <= t.hazard;
		flush       <= t.flush;
		wb_en       <= t.wb_en;
		wb_dest     <= t.wb_dest;
		wb_value    <= t.wb_value;
	endtask

	task automatic check_ex(int i);
		test_t t;
		t = tests[i];
		check_ctrl(i + 1, "ctrl", t.exp_ctrl, ex.ctrl);
		check_word(i + 1, "pc", pc_of(i), ex.pc);
		check_word(i + 1, "rn_val", t.exp_rn_val, ex.rn_val);
		check_word(i + 1, "rm_val", t.exp_rm_val, ex.rm_val);
		check_reg_addr(i + 1, "ex.rn", t.instruction[19:16], ex.rn);
		check_reg_addr(i + 1, "ex.src2", t.exp_src2, ex.src2);
		check_reg_addr(i + 1, "dest", t.instruction[15:12], ex.dest);
		check_bit(i + 1, "two_src", t.exp_two_src, ex.two_src);
		check_imm24(i + 1, "imm24", imm24_t'(t.instruction[23:0]), ex.imm24);
		check_shift_operand(i + 1, "shift_operand", t.instruction[11:0],
			ex.shift_operand);
	endtask

	task automatic finish_test(int idx);
		if (errs[idx] == 0) begin
			pass_count++;
			$display("%s: ok", names[idx]);
		end else begin
			fail_count++;
			$display("%s: FAILED with %0d errors", names[idx], errs[idx]);
		end
	endtask

	initial begin
		int last;
		reset       <= 1'b1;
		pc          <= '0;
		instruction <= '0;
		status      <= '0;
		hazard      <= 1'b0;
		flush       <= 1'b0;
		wb_en       <= 1'b0;
		wb_dest     <= '0;
		wb_value    <= '0;
		pass_count = 0;
		fail_count = 0;
		seed = 32'h40ef3949;
		names.push_back("reset");
		errs.push_back(0);
		build_table();
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_bundle(0, "ex", id_out_t'('0), ex);
		finish_test(0);
		// Entry i is driven while entry i - 1 shows up on ex
		for (int i = 0; i < tests.size(); i++) begin
			@(posedge clk);
			drive(i);
			@(negedge clk);
			check_reg_addr(i + 1, "rn port", tests[i].instruction[19:16], rn);
			check_reg_addr(i + 1, "src2 port", tests[i].exp_src2, src2);
			if (i > 0) begin
				check_ex(i - 1);
				finish_test(i);
			end
		end
		last = tests.size() - 1;
		@(posedge clk);
		hazard <= 1'b0;
		flush  <= 1'b0;
		wb_en  <= 1'b0;
		@(negedge clk);
		check_ex(last);
		finish_test(last + 1);
		$display("Tests: %0d ok, %0d failing", pass_count, fail_count);
		if (fail_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		int limit;
		#1;
		limit = (tests.size() + 20) * 100;
		#(limit);
		$display("Timeout: the decode run did not finish within %0d time units", limit);
		$display("Test failed");
		$finish;
	end

endmodule

//--- project.f
hw/arm_pkg.sv
hw/control_unit.sv
hw/cond_check.sv
hw/register_file.sv
hw/id_stage.sv
hw/id_ex_reg.sv
hw/decode_top.sv
verif/decode_tb.sv

//--- run.sh
#!/bin/sh
# Builds the decode testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module decode_tb -o decode_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

output=$(./obj_dir/decode_sim)
sim_status=$?
printf '%s\n' "$output"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q "^Test passed$"; then
	exit 0
else
	exit 1
fi
